// File: filelist.f
+incdir+tests
source/rfPkg.sv
source/writeDecode.sv
source/shadowBank.sv
source/registerBank.sv
source/rf.sv
tests/rfTb.sv

// File: runSim.sh
#!/bin/sh
# Builds the register file testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module rfTb -f filelist.f -o rfSim \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/rfSim > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Run failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "Run ended without a verdict"; exit 1; }
echo "Run passed"
exit 0

// File: tests/rfModel.svh
`ifndef rfModelSvh
`define rfModelSvh

// Reference model of the register file, included into the testbench top
// Uses errorCount, checkCount and abortRun from the including module

// Live bank and checkpoint bank as the rules describe them
regArray_t refLive;
regArray_t refShadow;

// Both banks clear while reset is low
task automatic clearModel();
  for (int i = 1; i < NumRegs; i++) begin
    refLive[i] = '0;
    refShadow[i] = '0;
  end
endtask

// One rising edge, every rule works on the values from before the edge
task automatic advanceModel(
  input logic    wr,
  input regSel_t sel,
  input rfData_t data,
  input logic    sv,
  input logic    rs
);
  regArray_t oldLive;
  regArray_t oldShadow;
  oldLive = refLive;
  oldShadow = refShadow;
  // Restore wins over a write on the same edge
  if (rs) begin
    refLive = oldShadow;
  end else if (wr && (sel != '0)) begin
    refLive[sel] = data;
  end
  // Snapshot never sees a write from its own cycle
  if (sv) begin
    refShadow = oldLive;
  end
endtask

// Register zero has no storage and reads as zero
function automatic rfData_t refRead(input regSel_t sel);
  rfData_t value;
  if (sel == '0) begin
    value = '0;
  end else begin
    value = refLive[sel];
  end
  return value;
endfunction

// Single compare used by every check in the testbench
task automatic compareValues(
  input rfData_t actual,
  input rfData_t expected,
  input string   what
);
  checkCount++;
  if (actual !== expected) begin
    errorCount++;
    $display("FAILED at time %0t: %s, got 32'h%08h, expected 32'h%08h",
      $time, what, actual, expected);
    abortRun();
  end
endtask

// Expected read of a stored image, register zero excluded from storage
function automatic rfData_t imageRead(input regArray_t image, input regSel_t sel);
  rfData_t value;
  if (sel == '0) begin
    value = '0;
  end else begin
    value = image[sel];
  end
  return value;
endfunction

`endif

// File: tests/rfTb.sv
`timescale 1ns/1ps

module rfTb import rfPkg::*; ();

  localparam int unsigned Seed = 32'h877e_b19b;
  localparam int HalfPeriod = 2;
  localparam int WriteCount = 200;
  localparam int RandomOps = 2000;

  // One op per clock cycle, summed over reset and every directed phase
  localparam int ResetOps = 3;
  localparam int SweepOps = NumRegs;
  localparam int DirectedOps = ResetOps + SweepOps + 2 * WriteCount
    + (NumRegs + SweepOps) + (10 + SweepOps) + (6 + SweepOps)
    + (NumRegs + 1 + SweepOps + 1 + SweepOps) + 1;
  localparam int NumOps = DirectedOps + RandomOps;
  localparam int WatchdogNs = (NumOps + 20) * 8;

  logic    clk;
  logic    arstN;
  regSel_t read1Sel;
  regSel_t read2Sel;
  regSel_t writeSel;
  rfData_t writeData;
  logic    write;
  logic    save;
  logic    restore;
  rfData_t read1Data;
  rfData_t read2Data;

  int errorCount;
  int checkCount;

  // Images kept by the stimulus, independent of the model arrays
  regArray_t fillImage;
  regArray_t saveImage;
  regArray_t swapImage;

  task automatic abortRun();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  `include "rfModel.svh"

  rf dut0 (
    .clk       (clk),
    .arstN     (arstN),
    .read1Sel  (read1Sel),
    .read2Sel  (read2Sel),
    .writeSel  (writeSel),
    .writeData (writeData),
    .write     (write),
    .save      (save),
    .restore   (restore),
    .read1Data (read1Data),
    .read2Data (read2Data)
  );

  always #HalfPeriod clk = ~clk;

  // Model follows the DUT edge by edge
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      clearModel();
    end else begin
      advanceModel(write, writeSel, writeData, save, restore);
    end
  end

  // Mid-cycle compare of both read ports against the model
  always @(negedge clk) begin
    compareValues(read1Data, refRead(read1Sel), "read port 1 against model");
    compareValues(read2Data, refRead(read2Sel), "read port 2 against model");
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
    abortRun();
  end

  // Present one operation just after a rising edge
  task automatic applyOp(
    input logic    wr,
    input regSel_t wSel,
    input rfData_t wData,
    input logic    sv,
    input logic    rs,
    input regSel_t r1,
    input regSel_t r2
  );
    @(posedge clk);
    #1;
    write = wr;
    writeSel = wSel;
    writeData = wData;
    save = sv;
    restore = rs;
    read1Sel = r1;
    read2Sel = r2;
  endtask

  // Idle cycle with reads, checked in the middle of that cycle
  task automatic checkRead(
    input regSel_t sel1,
    input rfData_t exp1,
    input regSel_t sel2,
    input rfData_t exp2,
    input string   what
  );
    applyOp(1'b0, '0, '0, 1'b0, 1'b0, sel1, sel2);
    @(negedge clk);
    compareValues(read1Data, exp1, {what, ", port 1"});
    compareValues(read2Data, exp2, {what, ", port 2"});
  endtask

  // Every selector on both ports, port 2 walks the other way
  task automatic checkAllRegs(input regArray_t image, input string what);
    regSel_t s1;
    regSel_t s2;
    for (int i = 0; i < NumRegs; i++) begin
      s1 = regSel_t'(i);
      s2 = regSel_t'(NumRegs - 1 - i);
      checkRead(s1, imageRead(image, s1), s2, imageRead(image, s2), what);
    end
  endtask

  task automatic checkResetState();
    for (int i = 0; i < NumRegs; i++) begin
      checkRead(regSel_t'(i), '0, regSel_t'(NumRegs - 1 - i), '0, "read after reset");
    end
  endtask

  // Write a random nonzero register, then read it back on both ports
  task automatic writeReadBurst();
    regSel_t sel;
    rfData_t data;
    for (int n = 0; n < WriteCount; n++) begin
      sel = regSel_t'($urandom_range(NumRegs - 1, 1));
      data = $urandom;
      applyOp(1'b1, sel, data, 1'b0, 1'b0, regSel_t'($urandom), regSel_t'($urandom));
      checkRead(sel, data, sel, data, "read back of last write");
    end
  endtask

  task automatic zeroRegisterTest();
    rfData_t data;
    for (int i = 1; i < NumRegs; i++) begin
      data = $urandom;
      fillImage[i] = data;
      applyOp(1'b1, regSel_t'(i), data, 1'b0, 1'b0, '0, regSel_t'(i));
    end
    // Nonzero data at selector zero must not land anywhere
    applyOp(1'b1, '0, 32'hdead_beef, 1'b0, 1'b0, '0, '0);
    checkAllRegs(fillImage, "bank after write to register zero");
  endtask

  task automatic saveRestoreTest();
    regSel_t sel;
    applyOp(1'b0, '0, '0, 1'b1, 1'b0, '0, '0);
    saveImage = fillImage;
    for (int n = 0; n < 8; n++) begin
      sel = regSel_t'($urandom_range(NumRegs - 1, 1));
      applyOp(1'b1, sel, $urandom, 1'b0, 1'b0, sel, '0);
    end
    applyOp(1'b0, '0, '0, 1'b0, 1'b1, '0, '0);
    checkAllRegs(saveImage, "bank after save, writes and restore");
  endtask

  task automatic restoreOverWriteTest();
    regSel_t sel;
    regSel_t target;
    for (int n = 0; n < 4; n++) begin
      sel = regSel_t'($urandom_range(NumRegs - 1, 1));
      applyOp(1'b1, sel, $urandom, 1'b0, 1'b0, '0, sel);
    end
    target = regSel_t'($urandom_range(NumRegs - 1, 1));
    // Write data differs from the shadow word in every bit
    applyOp(1'b1, target, ~saveImage[target], 1'b0, 1'b1, '0, '0);
    checkRead(target, saveImage[target], '0, '0, "restore against a same-cycle write");
    checkAllRegs(saveImage, "bank after restore with a write");
  endtask

  task automatic swapTest();
    rfData_t data;
    for (int i = 1; i < NumRegs; i++) begin
      data = $urandom;
      swapImage[i] = data;
      applyOp(1'b1, regSel_t'(i), data, 1'b0, 1'b0, regSel_t'(i), '0);
    end
    // Live holds swapImage, shadow still holds saveImage
    applyOp(1'b0, '0, '0, 1'b1, 1'b1, '0, '0);
    checkAllRegs(saveImage, "live bank after swap");
    applyOp(1'b0, '0, '0, 1'b0, 1'b1, '0, '0);
    checkAllRegs(swapImage, "live bank after restore following swap");
  endtask

  task automatic randomRun();
    int unsigned roll;
    logic    wr;
    logic    sv;
    logic    rs;
    regSel_t wSel;
    regSel_t r1;
    regSel_t r2;
    regSel_t lastSel;
    rfData_t wData;
    int      saves;
    int      restores;
    int      swaps;
    lastSel = regSel_t'(1);
    saves = 0;
    restores = 0;
    swaps = 0;
    for (int n = 0; n < RandomOps; n++) begin
      roll = $urandom_range(99, 0);
      wr = (roll < 70);
      sv = ($urandom_range(99, 0) < 3);
      rs = ($urandom_range(99, 0) < 3);
      wSel = regSel_t'($urandom);
      wData = $urandom;
      // Half the reads go back to the register written one op earlier
      r1 = ($urandom_range(1, 0) == 1) ? lastSel : regSel_t'($urandom);
      r2 = regSel_t'($urandom);
      applyOp(wr, wSel, wData, sv, rs, r1, r2);
      if (wr) begin
        lastSel = wSel;
      end
      if (sv && rs) begin
        swaps++;
      end else if (sv) begin
        saves++;
      end else if (rs) begin
        restores++;
      end
    end
    $display("Random run: %0d saves, %0d restores, %0d swaps", saves, restores, swaps);
  endtask

  initial begin
    errorCount = 0;
    checkCount = 0;
    clk = 1'b0;
    arstN = 1'b0;
    read1Sel = '0;
    read2Sel = '0;
    writeSel = '0;
    writeData = '0;
    write = 1'b0;
    save = 1'b0;
    restore = 1'b0;
    void'($urandom(Seed));
    clearModel();

    repeat (ResetOps) @(posedge clk);
    #1;
    arstN = 1'b1;

    checkResetState();
    writeReadBurst();
    zeroRegisterTest();
    saveRestoreTest();
    restoreOverWriteTest();
    swapTest();
    randomRun();

    // Let the last random op reach its mid-cycle compare
    @(posedge clk);
    @(negedge clk);
    $display("%0d compares done", checkCount);
    if (errorCount == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      abortRun();
    end
  end

endmodule

// File: source/rf.sv
`timescale 1ns/1ps

module rf import rfPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  regSel_t read1Sel,
  input  regSel_t read2Sel,
  input  regSel_t writeSel,
  input  rfData_t writeData,
  input  logic    write,
  input  logic    save,
  input  logic    restore,
  output rfData_t read1Data,
  output rfData_t read2Data
);

  regMask_t  writeEn;
  logic      loadShadow;
  regArray_t liveRegs;
  regArray_t savedRegs;

  // Write side, restore priority is settled in the decoder
  writeDecode decode0 (
    .writeSel   (writeSel),
    .write      (write),
    .restore    (restore),
    .writeEn    (writeEn),
    .loadShadow (loadShadow)
  );

  // Live registers and both read ports
  registerBank live0 (
    .clk        (clk),
    .arstN      (arstN),
    .writeEn    (writeEn),
    .loadShadow (loadShadow),
    .writeData  (writeData),
    .savedRegs  (savedRegs),
    .read1Sel   (read1Sel),
    .read2Sel   (read2Sel),
    .read1Data  (read1Data),
    .read2Data  (read2Data),
    .liveRegs   (liveRegs)
  );

  // Save and restore on the same edge swap the two banks
  shadowBank shadow0 (
    .clk       (clk),
    .arstN     (arstN),
    .save      (save),
    .liveRegs  (liveRegs),
    .savedRegs (savedRegs)
  );

endmodule

// File: source/registerBank.sv
`timescale 1ns/1ps

module registerBank import rfPkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  regMask_t  writeEn,
  input  logic      loadShadow,
  input  rfData_t   writeData,
  input  regArray_t savedRegs,
  input  regSel_t   read1Sel,
  input  regSel_t   read2Sel,
  output rfData_t   read1Data,
  output rfData_t   read2Data,
  output regArray_t liveRegs
);

  // Next value for each word: shadow copy on restore, else the write data
  regArray_t nextRegs;

  // Selector zero is the hardwired zero register
  function automatic rfData_t pickReg(regSel_t sel, regArray_t regs);
    rfData_t value;
    if (sel == '0) begin
      value = '0;
    end else begin
      value = regs[sel];
    end
    return value;
  endfunction

  always_comb begin
    for (int i = 1; i < NumRegs; i++) begin
      nextRegs[i] = loadShadow ? savedRegs[i] : writeData;
    end
  end

  for (genvar i = 1; i < NumRegs; i++) begin : gWord
    always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
        liveRegs[i] <= '0;
      end else if (writeEn[i]) begin
        liveRegs[i] <= nextRegs[i];
      end
    end
  end

  // Both ports are plain indexed selects of the live bank
  assign read1Data = pickReg(read1Sel, liveRegs);
  assign read2Data = pickReg(read2Sel, liveRegs);

  // Register zero reads as zero on either port, whatever was written to it
  assert property (@(posedge clk) disable iff (!arstN)
    (read1Sel == '0) |-> (read1Data == '0))
    else $error("registerBank: read port 1 returned nonzero for register zero");

  assert property (@(posedge clk) disable iff (!arstN)
    (read2Sel == '0) |-> (read2Data == '0))
    else $error("registerBank: read port 2 returned nonzero for register zero");

endmodule

// File: source/shadowBank.sv
`timescale 1ns/1ps

module shadowBank import rfPkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  logic      save,
  input  regArray_t liveRegs,
  output regArray_t savedRegs
);

  // Checkpoint copy, one word per live register
  for (genvar i = 1; i < NumRegs; i++) begin : gWord
    always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
        savedRegs[i] <= '0;
      end else if (save) begin
        // Takes the pre-edge live value, so a same-cycle write is not captured
        savedRegs[i] <= liveRegs[i];
      end
    end
  end

endmodule

// File: source/writeDecode.sv
`timescale 1ns/1ps

module writeDecode import rfPkg::*; (
  input  regSel_t  writeSel,
  input  logic     write,
  input  logic     restore,
  output regMask_t writeEn,
  output logic     loadShadow
);

  // Restore wins over a normal write, so the data source is picked here
  assign loadShadow = restore;

  always_comb begin
    writeEn = '0;
    // Register zero has no storage and never gets an enable
    for (int i = 1; i < NumRegs; i++) begin
      if (restore) begin
        writeEn[i] = 1'b1;
      end else begin
        writeEn[i] = write && (writeSel == regSel_t'(i));
      end
    end
  end

  // Outside a restore the decode is one-hot or idle
  always_comb begin
    assert final (restore || $onehot0(writeEn))
      else $error("writeDecode: more than one write enable without restore");
  end

endmodule

// File: source/rfPkg.sv
package rfPkg;

  // Register width and selector width follow from the instruction set
  localparam int DataWidth = 32;
  localparam int SelWidth = 5;

  // Addressable registers, register zero included
  localparam int NumRegs = 32;

  // One register value
  typedef logic [DataWidth-1:0] rfData_t;

  // Register selector as it arrives on the read and write ports
  typedef logic [SelWidth-1:0] regSel_t;

  // One bit per addressable register; bit zero stays clear
  typedef logic [NumRegs-1:0] regMask_t;

  // Whole bank of stored registers, register zero has no storage
  typedef rfData_t regArray_t [1:NumRegs-1];

endpackage
